// ==== verilog/audio_pkg.sv ====
// audio engine constants and the FSM state types of the fetch and mix stages
`default_nettype none

package audio_pkg;

    localparam int NCHAN     = 4;      // voices
    localparam int CHAN_W    = 2;      // voice index width
    localparam int VOL_W     = 7;      // unsigned volume
    localparam int PERIOD_W  = 15;
    localparam int LEN_W     = 15;     // sample words minus one
    localparam int DAC_W     = 8;
    localparam int ACC_W     = 18;     // mix accumulator
    localparam int VOL_SHIFT = 6;      // full volume is 64

    // one signed 8-bit sample, two of them per memory word
    typedef logic signed [7:0] sample_t;

    // round-robin memory fetcher
    typedef enum logic {
        FETCH_ISSUE,
        FETCH_WAIT
    } fetch_state_e;

    // two cycles per voice in the mixer
    typedef enum logic {
        MIX_MULT,
        MIX_ACCUM
    } mix_state_e;

endpackage

`default_nettype wire

// ==== verilog/bus_pkg.sv ====
// host bus and sample memory widths, word types and the register map
`default_nettype none

package bus_pkg;

    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;
    localparam int MEM_ADDR_W = 16;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;     // word address
    typedef logic [15:0]           mem_word_t;

    // word offset inside the 0x20 byte block of one voice
    typedef enum logic [2:0] {
        REG_CTRL,
        REG_VOL,
        REG_PERIOD,
        REG_START,
        REG_LENGTH
    } reg_sel_e;

    localparam logic [AXI_ADDR_W-1:0] STATUS_ADDR = 8'h80;   // sticky reload bits
    localparam logic [1:0]            RESP_OKAY   = 2'd0;
    localparam logic [1:0]            RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/audio_ifs.sv ====
// voice settings bundle and the current voice samples between the engine stages
`default_nettype none
`timescale 1ns/1ps

interface voice_cfg_if import audio_pkg::*, bus_pkg::*; ();

    logic [NCHAN-1:0]               enable;
    logic [NCHAN-1:0]               restart;    // one-cycle strobes
    logic [NCHAN-1:0][VOL_W-1:0]    vol_l;
    logic [NCHAN-1:0][VOL_W-1:0]    vol_r;
    logic [NCHAN-1:0][PERIOD_W-1:0] period;
    mem_addr_t [NCHAN-1:0]          start;
    logic [NCHAN-1:0][LEN_W-1:0]    length;
    logic [NCHAN-1:0]               reload;     // back from the fetch stage

    modport regs  (output enable, restart, vol_l, vol_r, period, start, length,
                   input reload);
    modport fetch (input enable, restart, period, start, length, output reload);
    modport mixer (input vol_l, vol_r);

endinterface

interface voice_out_if import audio_pkg::*; ();

    sample_t [NCHAN-1:0] sample;    // sample each voice is playing now

    modport source (output sample);
    modport sink   (input sample);

endinterface

`default_nettype wire

// ==== verilog/audio_regs.sv ====
// AXI4-Lite register block for the voice settings, restart strobes and reload status
`default_nettype none
`timescale 1ns/1ps

module audio_regs import audio_pkg::*, bus_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [AXI_ADDR_W-1:0] s_awaddr_i,
    input  wire logic                  s_awvalid_i,
    output      logic                  s_awready_o,
    input  wire logic [AXI_DATA_W-1:0] s_wdata_i,
    input  wire logic                  s_wvalid_i,
    output      logic                  s_wready_o,
    output      logic [1:0]            s_bresp_o,
    output      logic                  s_bvalid_o,
    input  wire logic                  s_bready_i,
    input  wire logic [AXI_ADDR_W-1:0] s_araddr_i,
    input  wire logic                  s_arvalid_i,
    output      logic                  s_arready_o,
    output      logic [AXI_DATA_W-1:0] s_rdata_o,
    output      logic [1:0]            s_rresp_o,
    output      logic                  s_rvalid_o,
    input  wire logic                  s_rready_i,
    voice_cfg_if.regs                  cfg
);

logic                  wr_fire;
logic                  rd_fire;
logic [CHAN_W-1:0]     wr_voice;
logic [CHAN_W-1:0]     rd_voice;
reg_sel_e              wr_sel;
reg_sel_e              rd_sel;
logic [NCHAN-1:0]      status;     // sticky reload flags
logic [AXI_DATA_W-1:0] rd_mux;

// true for the status word and the five words of each voice
function automatic logic map_ok(input logic [AXI_ADDR_W-1:0] a);
    if (a[AXI_ADDR_W-1]) begin
        return a == STATUS_ADDR;
    end
    return a[4:2] <= REG_LENGTH;
endfunction

// AW and W are taken together, and only with no response pending
assign wr_fire     = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
assign s_awready_o = wr_fire;
assign s_wready_o  = wr_fire;
assign rd_fire     = s_arvalid_i && !s_rvalid_o;
assign s_arready_o = rd_fire;

assign wr_voice = s_awaddr_i[5 +: CHAN_W];
assign wr_sel   = reg_sel_e'(s_awaddr_i[4:2]);
assign rd_voice = s_araddr_i[5 +: CHAN_W];
assign rd_sel   = reg_sel_e'(s_araddr_i[4:2]);

always_comb begin
    rd_mux = '0;
    if (s_araddr_i == STATUS_ADDR) begin
        rd_mux[NCHAN-1:0] = status;
    end else if (!s_araddr_i[AXI_ADDR_W-1]) begin
        case (rd_sel)
            REG_CTRL:   rd_mux[0] = cfg.enable[rd_voice];
            REG_VOL: begin
                rd_mux[VOL_W-1:0] = cfg.vol_l[rd_voice];
                rd_mux[8 +: VOL_W] = cfg.vol_r[rd_voice];
            end
            REG_PERIOD: rd_mux[PERIOD_W-1:0] = cfg.period[rd_voice];
            REG_START:  rd_mux[MEM_ADDR_W-1:0] = cfg.start[rd_voice];
            REG_LENGTH: rd_mux[LEN_W-1:0] = cfg.length[rd_voice];
            default:    rd_mux = '0;    // holes in a voice block
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        cfg.enable  <= '0;
        cfg.restart <= '0;
        cfg.vol_l   <= '0;
        cfg.vol_r   <= '0;
        cfg.period  <= '0;
        cfg.start   <= '0;
        cfg.length  <= '0;
        status      <= '0;
        s_bvalid_o  <= 1'b0;
        s_rvalid_o  <= 1'b0;
    end else begin
        cfg.restart <= '0;
        status      <= status | cfg.reload;
        if (wr_fire) begin
            s_bvalid_o <= 1'b1;
            if (s_awaddr_i == STATUS_ADDR) begin
                status <= (status & ~s_wdata_i[NCHAN-1:0]) | cfg.reload;  // new reloads win
            end else if (!s_awaddr_i[AXI_ADDR_W-1]) begin
                case (wr_sel)
                    REG_CTRL: begin
                        cfg.enable[wr_voice]  <= s_wdata_i[0];
                        cfg.restart[wr_voice] <= s_wdata_i[1];
                    end
                    REG_VOL: begin
                        cfg.vol_l[wr_voice] <= s_wdata_i[VOL_W-1:0];
                        cfg.vol_r[wr_voice] <= s_wdata_i[8 +: VOL_W];
                    end
                    REG_PERIOD: cfg.period[wr_voice] <= s_wdata_i[PERIOD_W-1:0];
                    REG_START:  cfg.start[wr_voice]  <= s_wdata_i[MEM_ADDR_W-1:0];
                    REG_LENGTH: cfg.length[wr_voice] <= s_wdata_i[LEN_W-1:0];
                    default: ;
                endcase
            end
        end else if (s_bready_i) begin
            s_bvalid_o <= 1'b0;
        end
        if (rd_fire) begin
            s_rvalid_o <= 1'b1;
        end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
        end
    end
end

// response payload
always_ff @(posedge clk) begin
    if (wr_fire) begin
        s_bresp_o <= map_ok(s_awaddr_i) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
        s_rdata_o <= rd_mux;
        s_rresp_o <= map_ok(s_araddr_i) ? RESP_OKAY : RESP_SLVERR;
    end
end

endmodule

`default_nettype wire

// ==== verilog/voice_fetch.sv ====
// voice sequencing with period and length counters and the round-robin sample fetcher
`default_nettype none
`timescale 1ns/1ps

module voice_fetch import audio_pkg::*, bus_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    voice_cfg_if.fetch      cfg,
    voice_out_if.source     smp,
    output      logic       mem_req_o,
    output      mem_addr_t  mem_addr_o,
    input  wire logic       mem_ack_i,
    input  wire mem_word_t  mem_data_i
);

logic [NCHAN-1:0][PERIOD_W:0] period_cnt;    // msb set means expired
logic [NCHAN-1:0][LEN_W:0]    length_cnt;    // msb set means reload
logic [NCHAN-1:0][LEN_W:0]    len_next;
mem_addr_t [NCHAN-1:0]        addr;          // next word to fetch
mem_word_t [NCHAN-1:0]        buff;
sample_t [NCHAN-1:0]          low_byte;      // second sample of the word
logic [NCHAN-1:0]             second;        // next expiry plays the low byte
logic [NCHAN-1:0]             fetch;         // word wanted and not yet issued
logic [NCHAN-1:0]             buff_ok;
logic [NCHAN-1:0]             expire;
logic [NCHAN-1:0]             issue_hit;
logic [NCHAN-1:0]             ack_hit;
logic [CHAN_W-1:0]            fchan;
fetch_state_e                 fstate;

always_comb begin
    for (int i = 0; i < NCHAN; i++) begin
        len_next[i]  = length_cnt[i] - 1'b1;
        expire[i]    = period_cnt[i][PERIOD_W] && cfg.enable[i];
        issue_hit[i] = fstate == FETCH_ISSUE && fchan == CHAN_W'(i) && fetch[i] && !buff_ok[i];
        ack_hit[i]   = fstate == FETCH_WAIT && fchan == CHAN_W'(i) && mem_req_o && mem_ack_i;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        period_cnt <= '0;
        length_cnt <= '0;
        addr       <= '0;
        buff       <= '0;
        low_byte   <= '0;
        second     <= '0;
        fetch      <= '0;
        buff_ok    <= '0;
        smp.sample <= '0;
        cfg.reload <= '0;
    end else begin
        for (int i = 0; i < NCHAN; i++) begin
            cfg.reload[i] <= 1'b0;
            period_cnt[i] <= period_cnt[i] - 1'b1;
            if (issue_hit[i]) begin
                fetch[i] <= 1'b0;                        // handed to the fetcher
            end
            if (expire[i]) begin
                second[i]     <= !second[i];
                period_cnt[i] <= {1'b0, cfg.period[i]};
                smp.sample[i] <= second[i] ? low_byte[i] : sample_t'(buff[i][15:8]);
                low_byte[i]   <= buff[i][7:0];
                buff_ok[i]    <= 1'b0;
                // a word still waiting for the fetcher keeps its address
                if (second[i] && (!(fetch[i] && !issue_hit[i]) || length_cnt[i][LEN_W])) begin
                    fetch[i] <= 1'b1;
                    if (length_cnt[i][LEN_W] || len_next[i][LEN_W]) begin
                        addr[i]       <= cfg.start[i];
                        length_cnt[i] <= {1'b0, cfg.length[i]};
                        cfg.reload[i] <= 1'b1;
                    end else begin
                        addr[i]       <= addr[i] + 1'b1;
                        length_cnt[i] <= len_next[i];
                    end
                end
            end
            if (ack_hit[i]) begin
                buff[i]    <= mem_data_i;
                buff_ok[i] <= 1'b1;
            end
            if (cfg.restart[i]) begin
                length_cnt[i][LEN_W]    <= 1'b1;    // force reload
                period_cnt[i][PERIOD_W] <= 1'b1;    // force expiry
                buff_ok[i]              <= 1'b0;
                second[i]               <= 1'b1;
            end
            if (!cfg.enable[i]) begin
                length_cnt[i][LEN_W]    <= 1'b1;
                period_cnt[i][PERIOD_W] <= 1'b1;
                second[i]               <= 1'b0;
                fetch[i]                <= 1'b0;    // no new requests while off
            end
        end
    end
end

// one voice per visit, the wait stretches while a request is open
always_ff @(posedge clk) begin
    if (reset_i) begin
        fstate     <= FETCH_ISSUE;
        fchan      <= '0;
        mem_req_o  <= 1'b0;
        mem_addr_o <= '0;
    end else begin
        case (fstate)
            FETCH_ISSUE: begin
                mem_addr_o <= addr[fchan];
                mem_req_o  <= issue_hit[fchan];
                fstate     <= FETCH_WAIT;
            end
            FETCH_WAIT: begin
                if (!mem_req_o || mem_ack_i) begin
                    mem_req_o <= 1'b0;
                    fchan     <= fchan + 1'b1;
                    fstate    <= FETCH_ISSUE;
                end
            end
            default: fstate <= FETCH_ISSUE;
        endcase
    end
end

endmodule

`default_nettype wire

// ==== verilog/voice_mixer.sv ====
// time-multiplexed multiply-accumulate of all voices into clamped unsigned DAC levels
`default_nettype none
`timescale 1ns/1ps

module voice_mixer import audio_pkg::*; (
    input  wire logic             clk,
    input  wire logic             reset_i,
    voice_cfg_if.mixer            cfg,
    voice_out_if.sink             smp,
    output      logic [DAC_W-1:0] level_l_o,
    output      logic [DAC_W-1:0] level_r_o
);

mix_state_e                mstate;
logic [CHAN_W-1:0]         mchan;
sample_t                   smp_q;
logic signed [VOL_W:0]     vol_l_q;    // always positive
logic signed [VOL_W:0]     vol_r_q;
logic signed [15:0]        prod_l;
logic signed [15:0]        prod_r;
logic signed [ACC_W-1:0]   acc_l;
logic signed [ACC_W-1:0]   acc_r;

// clamp to the 8-bit signed range after the volume shift, then offset to unsigned
function automatic logic [DAC_W-1:0] to_level(input logic signed [ACC_W-1:0] acc);
    if (acc < -(128 <<< VOL_SHIFT)) begin
        return '0;
    end
    if (acc > (127 <<< VOL_SHIFT)) begin
        return '1;
    end
    return DAC_W'(acc >>> VOL_SHIFT) ^ {1'b1, {(DAC_W-1){1'b0}}};
endfunction

assign prod_l = smp_q * vol_l_q;
assign prod_r = smp_q * vol_r_q;

always_ff @(posedge clk) begin
    if (reset_i) begin
        mstate    <= MIX_MULT;
        mchan     <= '0;
        smp_q     <= '0;
        vol_l_q   <= '0;
        vol_r_q   <= '0;
        acc_l     <= '0;
        acc_r     <= '0;
        level_l_o <= 8'h80;     // silence
        level_r_o <= 8'h80;
    end else begin
        case (mstate)
            MIX_MULT: begin
                if (mchan == '0) begin      // round complete
                    level_l_o <= to_level(acc_l);
                    level_r_o <= to_level(acc_r);
                    acc_l     <= '0;
                    acc_r     <= '0;
                end
                smp_q   <= smp.sample[mchan];
                vol_l_q <= signed'({1'b0, cfg.vol_l[mchan]});
                vol_r_q <= signed'({1'b0, cfg.vol_r[mchan]});
                mstate  <= MIX_ACCUM;
            end
            MIX_ACCUM: begin
                acc_l  <= acc_l + ACC_W'(prod_l);
                acc_r  <= acc_r + ACC_W'(prod_r);
                mchan  <= mchan + 1'b1;
                mstate <= MIX_MULT;
            end
            default: mstate <= MIX_MULT;
        endcase
    end
end

endmodule

`default_nettype wire

// ==== verilog/pdm_dac.sv ====
// first-order delta-sigma converter from an unsigned level to a pulse-density bit
`default_nettype none
`timescale 1ns/1ps

module pdm_dac import audio_pkg::*; (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire logic [DAC_W-1:0] level_i,
    output      logic             pulse_o
);

logic [DAC_W:0] acc;    // carry on top

always_ff @(posedge clk) begin
    if (reset_i) begin
        acc <= '0;
    end else begin
        acc <= {1'b0, acc[DAC_W-1:0]} + {1'b0, level_i};
    end
end

assign pulse_o = acc[DAC_W];

endmodule

`default_nettype wire

// ==== verilog/audio_top.sv ====
// four-voice sample playback engine with AXI4-Lite host port and PDM outputs
`default_nettype none
`timescale 1ns/1ps

module audio_top import audio_pkg::*, bus_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [AXI_ADDR_W-1:0] s_awaddr_i,
    input  wire logic                  s_awvalid_i,
    output      logic                  s_awready_o,
    input  wire logic [AXI_DATA_W-1:0] s_wdata_i,
    input  wire logic                  s_wvalid_i,
    output      logic                  s_wready_o,
    output      logic [1:0]            s_bresp_o,
    output      logic                  s_bvalid_o,
    input  wire logic                  s_bready_i,
    input  wire logic [AXI_ADDR_W-1:0] s_araddr_i,
    input  wire logic                  s_arvalid_i,
    output      logic                  s_arready_o,
    output      logic [AXI_DATA_W-1:0] s_rdata_o,
    output      logic [1:0]            s_rresp_o,
    output      logic                  s_rvalid_o,
    input  wire logic                  s_rready_i,
    output      logic                  mem_req_o,
    output      mem_addr_t             mem_addr_o,
    input  wire logic                  mem_ack_i,
    input  wire mem_word_t             mem_data_i,
    output      logic                  pdm_l_o,
    output      logic                  pdm_r_o
);

voice_cfg_if cfg_if ();
voice_out_if smp_if ();

logic [DAC_W-1:0] level_l;
logic [DAC_W-1:0] level_r;

audio_regs u_regs (
    .clk(clk), .reset_i(reset_i),
    .s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
    .s_wdata_i(s_wdata_i), .s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o),
    .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
    .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
    .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o), .s_rvalid_o(s_rvalid_o),
    .s_rready_i(s_rready_i),
    .cfg(cfg_if)
);

voice_fetch u_fetch (
    .clk(clk), .reset_i(reset_i),
    .cfg(cfg_if), .smp(smp_if),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
    .mem_ack_i(mem_ack_i), .mem_data_i(mem_data_i)
);

voice_mixer u_mixer (
    .clk(clk), .reset_i(reset_i),
    .cfg(cfg_if), .smp(smp_if),
    .level_l_o(level_l), .level_r_o(level_r)
);

pdm_dac u_dac_l (.clk(clk), .reset_i(reset_i), .level_i(level_l), .pulse_o(pdm_l_o));
pdm_dac u_dac_r (.clk(clk), .reset_i(reset_i), .level_i(level_r), .pulse_o(pdm_r_o));

endmodule

`default_nettype wire

// ==== tests/audio_tb.sv ====
// directed testbench for the audio engine with AXI host tasks, sample memory model and PDM counters
`default_nettype none
`timescale 1ns/1ps

module audio_tb import audio_pkg::*, bus_pkg::*; ();

localparam int REG_BUDGET     = 20000;
localparam int FETCH_BUDGET   = 20000;   // fetch sequence runs twice
localparam int MIX_BUDGET     = 30000;
localparam int CLAMP_BUDGET   = 60000;
localparam int RESTART_BUDGET = 50000;
localparam int TOTAL_BUDGET   = REG_BUDGET + 2 * FETCH_BUDGET + MIX_BUDGET + CLAMP_BUDGET
                                + RESTART_BUDGET;
localparam int WAIT_LIMIT     = 2000;    // cycles allowed for any single wait

logic                  clk;
logic                  reset_i;
logic [AXI_ADDR_W-1:0] awaddr;
logic                  awvalid;
logic                  awready;
logic [AXI_DATA_W-1:0] wdata;
logic                  wvalid;
logic                  wready;
logic [1:0]            bresp;
logic                  bvalid;
logic                  bready;
logic [AXI_ADDR_W-1:0] araddr;
logic                  arvalid;
logic                  arready;
logic [AXI_DATA_W-1:0] rdata;
logic [1:0]            rresp;
logic                  rvalid;
logic                  rready;
logic                  mem_req;
mem_addr_t             mem_addr;
logic                  mem_ack = 1'b0;
mem_word_t             mem_data = '0;
logic                  pdm_l;
logic                  pdm_r;

mem_word_t mem [0:65535];       // sample memory
mem_addr_t addr_log [$];        // every requested address, in order
int        ack_delay;
int        wait_cnt = 0;
logic      held_req = 1'b0;
logic      held_ack = 1'b0;
mem_addr_t held_addr = '0;
integer    seed;
int        errors = 0;
int        proto_errors = 0;    // found by the memory port monitor
int        test_base;
int        tests_run = 0;
string     cur_test;

audio_top UUT (
    .clk(clk), .reset_i(reset_i),
    .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
    .s_wdata_i(wdata), .s_wvalid_i(wvalid), .s_wready_o(wready),
    .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
    .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
    .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_ack_i(mem_ack), .mem_data_i(mem_data),
    .pdm_l_o(pdm_l), .pdm_r_o(pdm_r)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// acknowledge after ack_delay cycles, data valid with the acknowledge
always @(posedge clk) begin
    mem_ack <= 1'b0;
    if (reset_i) begin
        wait_cnt <= 0;
    end else if (mem_req && !mem_ack) begin
        if (wait_cnt == 0) begin
            addr_log.push_back(mem_addr);   // first cycle of a new request
        end
        if (wait_cnt + 1 >= ack_delay) begin
            mem_ack  <= 1'b1;
            mem_data <= mem[mem_addr];
            wait_cnt <= 0;
        end else begin
            wait_cnt <= wait_cnt + 1;
        end
    end
end

// an open request keeps its address until acknowledged
always @(posedge clk) begin
    if (!reset_i && held_req && !held_ack) begin
        assert (mem_req && mem_addr == held_addr) else begin
            $display("memory request dropped or moved before acknowledge at %0t", $time);
            proto_errors++;
        end
    end
    held_req  <= mem_req;
    held_ack  <= mem_ack;
    held_addr <= mem_addr;
end

initial begin
    repeat (TOTAL_BUDGET) @(posedge clk);
    $display("watchdog expired after %0d cycles", TOTAL_BUDGET);
    $display("Test FAILED");
    $finish;
end

function automatic logic [AXI_ADDR_W-1:0] reg_addr(input int v, input int sel);
    return AXI_ADDR_W'(v * 32 + sel * 4);
endfunction

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
        $display("mismatch in %s, %s: expected %0h, actual %0h", cur_test, what,
                 expected, actual);
        errors++;
    end
endtask

task automatic check_between(input string what, input int lo, input int hi, input int actual);
    assert (actual >= lo && actual <= hi) else begin
        $display("mismatch in %s, %s: expected %0d to %0d, actual %0d", cur_test, what,
                 lo, hi, actual);
        errors++;
    end
endtask

task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                         input logic [1:0] exp_resp);
    int n;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    n = 0;
    @(posedge clk);
    while (!(awready && wready) && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
    end
    awvalid <= 1'b0;            // AW and W taken at this edge
    wvalid  <= 1'b0;
    @(posedge clk);
    while (!bvalid && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
    end
    bready <= 1'b0;
    assert (n < WAIT_LIMIT) else begin
        $display("%s: write to %0h never completed", cur_test, addr);
        errors++;
    end
    check_value($sformatf("write response at %0h", addr), exp_resp, bresp);
endtask

task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                        input logic [1:0] exp_resp);
    int n;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    n = 0;
    @(posedge clk);
    while (!arready && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
    end
    arvalid <= 1'b0;
    @(posedge clk);
    while (!rvalid && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
    end
    rready <= 1'b0;
    data = rdata;
    assert (n < WAIT_LIMIT) else begin
        $display("%s: read of %0h never completed", cur_test, addr);
        errors++;
    end
    check_value($sformatf("read response at %0h", addr), exp_resp, rresp);
endtask

task automatic apply_reset();
    @(posedge clk);
    reset_i <= 1'b1;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    @(posedge clk);
endtask

task automatic start_test(input string name);
    cur_test  = name;
    test_base = errors + proto_errors;
    ack_delay = 1;
    apply_reset();
endtask

task automatic finish_test();
    int n;
    n = errors + proto_errors - test_base;
    tests_run++;
    $display("%s: %s with %0d errors", cur_test, (n == 0) ? "passed" : "failed", n);
endtask

task automatic program_voice(input int v, input int period, input logic [15:0] start,
                             input int length, input int vol_l, input int vol_r);
    axi_write(reg_addr(v, REG_PERIOD), period, RESP_OKAY);
    axi_write(reg_addr(v, REG_START), {16'h0, start}, RESP_OKAY);
    axi_write(reg_addr(v, REG_LENGTH), length, RESP_OKAY);
    axi_write(reg_addr(v, REG_VOL), (vol_r << 8) | vol_l, RESP_OKAY);
endtask

task automatic wait_for_log(input int count);
    int n;
    n = 0;
    while (addr_log.size() < count && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
    end
    assert (n < WAIT_LIMIT) else begin
        $display("%s: only %0d of %0d memory requests seen", cur_test, addr_log.size(), count);
        errors++;
    end
endtask

task automatic count_ones(output int ones_l, output int ones_r);
    ones_l = 0;
    ones_r = 0;
    repeat (1024) begin
        @(posedge clk);
        ones_l += int'(pdm_l);
        ones_r += int'(pdm_r);
    end
endtask

task automatic test_register_readback();
    logic [31:0] wr_val [NCHAN][5];
    logic [31:0] mask [5];
    logic [31:0] rd;
    mask = '{32'h1, 32'h7f7f, 32'h7fff, 32'hffff, 32'h7fff};   // restart bit is not stored
    start_test("register readback");
    for (int v = 0; v < NCHAN; v++) begin
        for (int r = 0; r < 5; r++) begin
            wr_val[v][r] = $random(seed);
            axi_write(reg_addr(v, r), wr_val[v][r], RESP_OKAY);
        end
    end
    for (int v = 0; v < NCHAN; v++) begin
        for (int r = 0; r < 5; r++) begin
            axi_read(reg_addr(v, r), rd, RESP_OKAY);
            check_value($sformatf("voice %0d reg %0d", v, r), wr_val[v][r] & mask[r], rd);
        end
    end
    axi_read(8'h14, rd, RESP_SLVERR);       // hole inside voice 0
    check_value("hole read data", 32'h0, rd);
    axi_read(8'h90, rd, RESP_SLVERR);
    check_value("unmapped read data", 32'h0, rd);
    axi_write(8'h94, 32'h1234, RESP_SLVERR);
    finish_test();
endtask

task automatic test_fetch_sequence(input string name, input int delay);
    logic [15:0] exp_addr [4];
    logic [31:0] rd;
    int          base;
    exp_addr = '{16'h100, 16'h101, 16'h102, 16'h100};   // three words, then wrap
    start_test(name);
    ack_delay = delay;
    base = addr_log.size();
    program_voice(1, 3, 16'h100, 2, 0, 0);
    axi_write(reg_addr(1, REG_CTRL), 32'h1, RESP_OKAY);
    wait_for_log(base + 4);
    for (int i = 0; i < 4; i++) begin
        if (addr_log.size() > base + i) begin
            check_value($sformatf("request %0d address", i), exp_addr[i], addr_log[base + i]);
        end
    end
    axi_read(STATUS_ADDR, rd, RESP_OKAY);
    check_value("status after reload", 32'h2, rd);
    axi_write(reg_addr(1, REG_CTRL), 32'h0, RESP_OKAY);  // stop new reloads first
    axi_write(STATUS_ADDR, 32'h2, RESP_OKAY);
    axi_read(STATUS_ADDR, rd, RESP_OKAY);
    check_value("status after clear", 32'h0, rd);
    finish_test();
endtask

task automatic test_mixed_level();
    int ones_l;
    int ones_r;
    start_test("mixed level");
    for (int a = 'h200; a < 'h204; a++) begin
        mem[a] = 16'h2020;
    end
    program_voice(0, 3, 16'h200, 3, 64, 0);
    axi_write(reg_addr(0, REG_CTRL), 32'h1, RESP_OKAY);
    repeat (200) @(posedge clk);
    count_ones(ones_l, ones_r);
    // 0x20 at full volume sits 0x20 above the silence level 0x80
    check_between("left ones", 4 * 'ha0 - 4, 4 * 'ha0 + 4, ones_l);
    check_between("right ones", 4 * 'h80 - 4, 4 * 'h80 + 4, ones_r);
    finish_test();
endtask

task automatic play_all_voices(input logic [15:0] word, output int ones_l);
    int ones_r;
    mem[16'h300] = word;
    mem[16'h301] = word;
    for (int v = 0; v < NCHAN; v++) begin
        program_voice(v, 3, 16'h300, 1, 127, 0);
        axi_write(reg_addr(v, REG_CTRL), 32'h1, RESP_OKAY);
    end
    repeat (200) @(posedge clk);
    count_ones(ones_l, ones_r);
endtask

task automatic test_clamping();
    int ones_l;
    start_test("clamping");
    play_all_voices(16'h7f7f, ones_l);
    check_between("left ones at positive clamp", 1020, 1024, ones_l);
    apply_reset();
    play_all_voices(16'h8080, ones_l);
    check_between("left ones at negative clamp", 0, 4, ones_l);
    finish_test();
endtask

task automatic test_restart_disable();
    int base;
    int seen;
    int n;
    start_test("restart and disable");
    base = addr_log.size();
    program_voice(2, 40, 16'h400, 5, 0, 0);     // long period keeps the restart clear of fetches
    axi_write(reg_addr(2, REG_CTRL), 32'h1, RESP_OKAY);
    wait_for_log(base + 3);
    seen = addr_log.size();
    axi_write(reg_addr(2, REG_CTRL), 32'h3, RESP_OKAY);  // enable plus restart
    wait_for_log(seen + 1);
    if (addr_log.size() > seen) begin
        check_value("address after restart", 32'h400, addr_log[seen]);
    end
    for (int v = 0; v < NCHAN; v++) begin
        axi_write(reg_addr(v, REG_CTRL), 32'h0, RESP_OKAY);
    end
    repeat (4) @(posedge clk);
    n = 0;
    while (mem_req && n < WAIT_LIMIT) begin     // let an open request finish
        @(posedge clk);
        n++;
    end
    assert (n < WAIT_LIMIT) else begin
        $display("%s: request still open after disable", cur_test);
        errors++;
    end
    seen = addr_log.size();
    repeat (500) @(posedge clk);
    check_value("requests after disable", seen, addr_log.size());
    finish_test();
endtask

initial begin
    int total;
    seed    = 49288;
    reset_i = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    ack_delay = 1;
    for (int a = 0; a < 65536; a++) begin
        mem[a] = mem_word_t'($random(seed));
    end
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    test_register_readback();
    test_fetch_sequence("fetch sequence", 1);
    test_mixed_level();
    test_clamping();
    test_fetch_sequence("back-pressure", 7);
    test_restart_disable();
    total = errors + proto_errors;
    $display("%0d tests run, %0d errors", tests_run, total);
    if (total == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== audio_top.f ====
verilog/audio_pkg.sv
verilog/bus_pkg.sv
verilog/audio_ifs.sv
verilog/audio_regs.sv
verilog/voice_fetch.sv
verilog/voice_mixer.sv
verilog/pdm_dac.sv
verilog/audio_top.sv
tests/audio_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module audio_tb \
    -f audio_top.f --Mdir obj_dir -o audio_sim > build.log 2>&1 &&
./obj_dir/audio_sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "Test OK" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
